// ==== Makefile ====
# Verilator build and run for the AHB-Lite to APB bridge testbench

VERILATOR ?= verilator
TOP       ?= ahbApbBridgeTb
FILELIST  ?= ahbApbBridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== ahbApbBridge.f ====
hdl/ahbApbPkg.sv
hdl/ahbRequestCapture.sv
hdl/apbSlaveDecoder.sv
hdl/apbBridgeFsm.sv
hdl/byteLaneSteer.sv
hdl/ahbApbBridge.sv
sim/tbClockGen.sv
sim/ahbApbBridgeTb.sv

// ==== hdl/ahbApbBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahbApbBridge #(
        parameter int NumSlaves       = 4,
        parameter int SlaveWindowBits = 12,
        parameter int GuardLimit      = 9
) (
        input  logic                  Hclk,
        input  logic                  Hresetn,
        input  logic                  valid,
        input  ahbApbPkg::addrT       Haddr,
        input  logic                  Hwrite,
        input  ahbApbPkg::sizeT       Hsize,
        input  ahbApbPkg::dataT       Hwdata,
        input  ahbApbPkg::dataT       Prdata,
        output logic                  Hreadyout,
        output ahbApbPkg::dataT       Hrdata,
        output ahbApbPkg::addrT       Paddr,
        output logic                  Pwrite,
        output logic [NumSlaves-1:0]  Pselx,
        output logic                  Penable,
        output ahbApbPkg::dataT       Pwdata
);

        ahbApbPkg::ahbReqT req;

        logic active;
        logic captureAddr;
        logic captureData;
        logic readDone;

        assign Paddr  = req.addr;
        assign Pwrite = req.write;

        ahbRequestCapture i_capture (
                .Hclk        (Hclk),
                .Hresetn     (Hresetn),
                .Haddr       (Haddr),
                .Hwrite      (Hwrite),
                .Hsize       (Hsize),
                .Hwdata      (Hwdata),
                .captureAddr (captureAddr),
                .captureData (captureData),
                .req         (req)
        );

        apbSlaveDecoder #(
                .NumSlaves       (NumSlaves),
                .SlaveWindowBits (SlaveWindowBits),
                .GuardLimit      (GuardLimit)
        ) i_decoder (
                .req    (req),
                .active (active),
                .Pselx  (Pselx)
        );

        apbBridgeFsm i_fsm (
                .Hclk        (Hclk),
                .Hresetn     (Hresetn),
                .valid       (valid),
                .Hwrite      (Hwrite),
                .Hreadyout   (Hreadyout),
                .Penable     (Penable),
                .active      (active),
                .captureAddr (captureAddr),
                .captureData (captureData),
                .readDone    (readDone)
        );

        byteLaneSteer i_laneSteer (
                .Hclk     (Hclk),
                .Hresetn  (Hresetn),
                .req      (req),
                .Prdata   (Prdata),
                .readDone (readDone),
                .Pwdata   (Pwdata),
                .Hrdata   (Hrdata)
        );

endmodule

`default_nettype wire

// ==== hdl/ahbApbPkg.sv ====
`default_nettype none

package ahbApbPkg;

        localparam int AddrWidth = 32;
        localparam int DataWidth = 32;

        // Byte offset within a data word
        localparam int OffsetBits = $clog2(DataWidth / 8);

        typedef logic [AddrWidth-1:0] addrT;
        typedef logic [DataWidth-1:0] dataT;
        typedef logic [2:0]           sizeT;

        // Hsize encodings
        localparam sizeT SizeByte = 3'b000;
        localparam sizeT SizeHalf = 3'b001;
        localparam sizeT SizeWord = 3'b010;

        // One AHB transfer as held by the bridge
        typedef struct packed {
                addrT addr;
                logic write;
                sizeT size;
                dataT wdata;
        } ahbReqT;

        // One hot
        typedef enum logic [3:0] {
                Idle      = 4'b0001,
                WriteWait = 4'b0010,
                Setup     = 4'b0100,
                Access    = 4'b1000
        } bridgeStateT;

endpackage

`default_nettype wire

// ==== hdl/ahbRequestCapture.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahbRequestCapture (
        input  logic                Hclk,
        input  logic                Hresetn,
        input  ahbApbPkg::addrT     Haddr,
        input  logic                Hwrite,
        input  ahbApbPkg::sizeT     Hsize,
        input  ahbApbPkg::dataT     Hwdata,
        input  logic                captureAddr,
        input  logic                captureData,
        output ahbApbPkg::ahbReqT   req
);

        ahbApbPkg::addrT addrReg;
        logic            writeReg;
        ahbApbPkg::sizeT sizeReg;
        ahbApbPkg::dataT wdataReg;

        // Address phase
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (~Hresetn)
                begin
                        addrReg  <= '0;
                        writeReg <= 1'b0;
                        sizeReg  <= ahbApbPkg::SizeByte;
                end
                else if (captureAddr)
                begin
                        addrReg  <= Haddr;
                        writeReg <= Hwrite;
                        sizeReg  <= Hsize;
                end
        end

        // Write data arrives one cycle after the address
        always_ff @(posedge Hclk)
        begin
                if (captureData)
                begin
                        wdataReg <= Hwdata;
                end
        end

        // Held between strobes so Paddr and Pwdata stay put through setup and access
        assign req = '{
                addr:  addrReg,
                write: writeReg,
                size:  sizeReg,
                wdata: wdataReg
        };

endmodule

`default_nettype wire

// ==== hdl/apbBridgeFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module apbBridgeFsm (
        input  logic Hclk,
        input  logic Hresetn,
        input  logic valid,
        input  logic Hwrite,
        output logic Hreadyout,
        output logic Penable,
        output logic active,
        output logic captureAddr,
        output logic captureData,
        output logic readDone
);

        ahbApbPkg::bridgeStateT state;
        ahbApbPkg::bridgeStateT nextState;

        logic isWrite;   // Direction of the transfer in flight

        // Accept only from idle with no wait state pending
        assign captureAddr = (state == ahbApbPkg::Idle) && valid && Hreadyout;
        assign captureData = state == ahbApbPkg::WriteWait;

        assign active  = (state == ahbApbPkg::Setup) || (state == ahbApbPkg::Access);
        assign Penable = state == ahbApbPkg::Access;

        assign readDone = (state == ahbApbPkg::Access) && !isWrite;

        always_comb
        begin
                nextState = state;
                case (state)
                        ahbApbPkg::Idle:
                        begin
                                if (captureAddr)
                                begin
                                        nextState = Hwrite ? ahbApbPkg::WriteWait
                                                           : ahbApbPkg::Setup;
                                end
                        end
                        ahbApbPkg::WriteWait: nextState = ahbApbPkg::Setup;
                        ahbApbPkg::Setup:     nextState = ahbApbPkg::Access;
                        ahbApbPkg::Access:    nextState = ahbApbPkg::Idle;
                        default:              nextState = ahbApbPkg::Idle;
                endcase
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (~Hresetn)
                begin
                        state <= ahbApbPkg::Idle;
                end
                else
                begin
                        state <= nextState;
                end
        end

        // Wait states from the accept edge until access completes
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (~Hresetn)
                begin
                        Hreadyout <= 1'b1;
                        isWrite   <= 1'b0;
                end
                else if (captureAddr)
                begin
                        Hreadyout <= 1'b0;
                        isWrite   <= Hwrite;
                end
                else if (state == ahbApbPkg::Access)
                begin
                        Hreadyout <= 1'b1;
                end
        end

        // Wait states exactly while a transfer is in flight
        assert property (@(posedge Hclk) disable iff (~Hresetn)
                         Hreadyout == (state == ahbApbPkg::Idle))
        else $error("apbBridgeFsm: Hreadyout out of step with the state");

        // Data phase only for writes
        assert property (@(posedge Hclk) disable iff (~Hresetn) captureData |-> isWrite)
        else $error("apbBridgeFsm: write wait entered for a read");

endmodule

`default_nettype wire

// ==== hdl/apbSlaveDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module apbSlaveDecoder #(
        parameter int NumSlaves       = 4,
        parameter int SlaveWindowBits = 12,
        parameter int GuardLimit      = 9
) (
        input  ahbApbPkg::ahbReqT     req,
        input  logic                  active,
        output logic [NumSlaves-1:0]  Pselx
);

        localparam int IdxWidth = ahbApbPkg::AddrWidth - SlaveWindowBits;

        logic [IdxWidth-1:0] slaveIdx;
        logic                inRange;
        logic                guarded;

        // Window number of the held address
        assign slaveIdx = req.addr[ahbApbPkg::AddrWidth-1:SlaveWindowBits];

        assign inRange = slaveIdx < IdxWidth'(NumSlaves);
        assign guarded = req.addr < ahbApbPkg::addrT'(GuardLimit);   // Reserved low region

        always_comb
        begin
                for (int i = 0; i < NumSlaves; i++)
                begin
                        Pselx[i] = active && inRange && !guarded
                                   && (slaveIdx == IdxWidth'(i));
                end
        end

endmodule

`default_nettype wire

// ==== hdl/byteLaneSteer.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteLaneSteer (
        input  logic               Hclk,
        input  logic               Hresetn,
        input  ahbApbPkg::ahbReqT  req,
        input  ahbApbPkg::dataT    Prdata,
        input  logic               readDone,
        output ahbApbPkg::dataT    Pwdata,
        output ahbApbPkg::dataT    Hrdata
);

        // Little endian lane pick, zero extended into the low bits
        function automatic ahbApbPkg::dataT laneSelect(
                input ahbApbPkg::sizeT                 size,
                input logic [ahbApbPkg::OffsetBits-1:0] offset,
                input ahbApbPkg::dataT                 word
        );
                ahbApbPkg::dataT lane;
                lane = '0;
                case (size)
                        ahbApbPkg::SizeByte:
                        begin
                                lane = ahbApbPkg::dataT'(word[8*offset +: 8]);
                        end
                        ahbApbPkg::SizeHalf:
                        begin
                                if (!offset[0])
                                begin
                                        lane = ahbApbPkg::dataT'(word[16*offset[1] +: 16]);
                                end
                        end
                        ahbApbPkg::SizeWord:
                        begin
                                if (offset == '0)
                                begin
                                        lane = word;
                                end
                        end
                        default: lane = '0;   // Wider than the APB bus
                endcase
                return lane;
        endfunction

        logic [ahbApbPkg::OffsetBits-1:0] offset;

        assign offset = req.addr[ahbApbPkg::OffsetBits-1:0];

        assign Pwdata = laneSelect(req.size, offset, req.wdata);

        // Read data sampled at the end of access
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (~Hresetn)
                begin
                        Hrdata <= '0;
                end
                else if (readDone)
                begin
                        Hrdata <= laneSelect(req.size, offset, Prdata);
                end
        end

endmodule

`default_nettype wire

// ==== sim/ahbApbBridgeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahbApbBridgeTb;

        localparam int NumSlaves    = 4;
        localparam int ClockPeriod  = 40;
        localparam int ResetCycles  = 8;
        localparam int DriveDelay   = 2;
        localparam int CyclesPerRow = 8;
        localparam int NumFixed     = 15;
        localparam int NumRandom    = 12;
        localparam int Seed         = 88751;
        localparam int WindowSize   = 4096;   // Bytes per slave window
        localparam int GuardLimit   = 9;

        typedef struct packed {
                logic                 write;
                ahbApbPkg::addrT      addr;
                ahbApbPkg::sizeT      size;
                ahbApbPkg::dataT      wdata;
                ahbApbPkg::dataT      prdata;
                ahbApbPkg::dataT      expLane;
                logic [NumSlaves-1:0] expSel;
        } rowT;

        // write, addr, size, wdata, prdata, expected lane, expected Pselx (zero for none)
        localparam rowT FixedRows [NumFixed] = '{
                '{1'b0, 32'h0000_0010, 3'd2, 32'h0, 32'h89AB_CDEF, 32'h89AB_CDEF, 4'b0001},
                '{1'b1, 32'h0000_1000, 3'd2, 32'h1234_5678, 32'h0, 32'h1234_5678, 4'b0010},
                '{1'b1, 32'h0000_2001, 3'd0, 32'hA1B2_C3D4, 32'h0, 32'h0000_00C3, 4'b0100},
                '{1'b1, 32'h0000_3002, 3'd1, 32'hA1B2_C3D4, 32'h0, 32'h0000_A1B2, 4'b1000},
                '{1'b1, 32'h0000_3001, 3'd1, 32'hA1B2_C3D4, 32'h0, 32'h0, 4'b1000},
                '{1'b0, 32'h0000_1003, 3'd0, 32'h0, 32'h5566_7788, 32'h0000_0055, 4'b0010},
                '{1'b0, 32'h0000_2000, 3'd1, 32'h0, 32'h5566_7788, 32'h0000_7788, 4'b0100},
                '{1'b0, 32'h0000_1000, 3'd3, 32'h0, 32'h5566_7788, 32'h0, 4'b0010},
                '{1'b0, 32'h0000_0004, 3'd0, 32'h0, 32'h1122_3344, 32'h0000_0044, 4'b0000},
                '{1'b1, 32'h0000_0008, 3'd2, 32'h0BAD_F00D, 32'h0, 32'h0BAD_F00D, 4'b0000},
                '{1'b0, 32'h0000_0009, 3'd0, 32'h0, 32'hCAFE_F00D, 32'h0000_00F0, 4'b0001},
                '{1'b1, 32'h0000_4000, 3'd2, 32'h7654_3210, 32'h0, 32'h7654_3210, 4'b0000},
                '{1'b0, 32'h0007_F000, 3'd2, 32'h0, 32'h0F1E_2D3C, 32'h0F1E_2D3C, 4'b0000},
                '{1'b1, 32'h0000_1002, 3'd2, 32'hDEAD_BEEF, 32'h0, 32'h0, 4'b0010},
                '{1'b1, 32'h0000_0FFF, 3'd0, 32'h0BAD_CAFE, 32'h0, 32'h0000_000B, 4'b0001}
        };

        logic                 Hclk;
        logic                 Hresetn;
        logic                 valid;
        ahbApbPkg::addrT      Haddr;
        logic                 Hwrite;
        ahbApbPkg::sizeT      Hsize;
        ahbApbPkg::dataT      Hwdata;
        ahbApbPkg::dataT      Prdata;
        logic                 Hreadyout;
        ahbApbPkg::dataT      Hrdata;
        ahbApbPkg::addrT      Paddr;
        logic                 Pwrite;
        logic [NumSlaves-1:0] Pselx;
        logic                 Penable;
        ahbApbPkg::dataT      Pwdata;

        rowT rows[$];
        rowT curRow;
        int  step;   // Zero during the reset checks

        tbClockGen #(.Period(ClockPeriod), .ResetCycles(ResetCycles), .DriveDelay(DriveDelay))
                i_clockGen (.Hclk(Hclk), .Hresetn(Hresetn));

        ahbApbBridge #(
                .NumSlaves       (NumSlaves),
                .SlaveWindowBits (12),
                .GuardLimit      (GuardLimit)
        ) i_dut (
                .Hclk(Hclk), .Hresetn(Hresetn), .valid(valid), .Haddr(Haddr),
                .Hwrite(Hwrite), .Hsize(Hsize), .Hwdata(Hwdata), .Prdata(Prdata),
                .Hreadyout(Hreadyout), .Hrdata(Hrdata), .Paddr(Paddr), .Pwrite(Pwrite),
                .Pselx(Pselx), .Penable(Penable), .Pwdata(Pwdata)
        );

        // APB slave answers only in the access phase
        always_comb
                Prdata = Penable ? curRow.prdata : '0;

        task automatic stopOnMismatch(input string what, input string got, input string exp);
                $display("CHECK FAILED at time %0t: step %0d %s is %s, expected %s",
                         $time, step, what, got, exp);
                $display("ERRORS FOUND");
                $fatal(1, "Mismatch on %s", what);
        endtask

        task automatic checkData(input string what, input ahbApbPkg::dataT got,
                                 input ahbApbPkg::dataT exp);
                if (got !== exp)
                        stopOnMismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
        endtask

        task automatic checkAddr(input string what, input ahbApbPkg::addrT got,
                                 input ahbApbPkg::addrT exp);
                if (got !== exp)
                        stopOnMismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
        endtask

        task automatic checkSel(input string what, input logic [NumSlaves-1:0] got,
                                input logic [NumSlaves-1:0] exp);
                if (got !== exp)
                        stopOnMismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
        endtask

        task automatic checkFlag(input string what, input logic got, input logic exp);
                if (got !== exp)
                        stopOnMismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
        endtask

        task automatic checkCount(input string what, input int got, input int exp);
                if (got != exp)
                        stopOnMismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
        endtask

        // Little endian lane, low byte at offset zero
        function automatic ahbApbPkg::dataT expectedLane(input ahbApbPkg::sizeT size,
                        input ahbApbPkg::addrT addr, input ahbApbPkg::dataT word);
                int unsigned     byteOffset;
                ahbApbPkg::dataT shifted;
                ahbApbPkg::dataT lane;
                byteOffset = addr % 4;
                shifted    = word >> (8 * byteOffset);
                lane       = '0;
                if (size == ahbApbPkg::SizeByte)
                        lane = shifted & 32'h0000_00FF;
                else if (size == ahbApbPkg::SizeHalf && byteOffset % 2 == 0)
                        lane = shifted & 32'h0000_FFFF;
                else if (size == ahbApbPkg::SizeWord && byteOffset == 0)
                        lane = word;
                return lane;
        endfunction

        function automatic logic [NumSlaves-1:0] expectedSel(input ahbApbPkg::addrT addr);
                int unsigned window;
                window = addr / WindowSize;
                if (addr >= GuardLimit && window < NumSlaves)
                        return NumSlaves'(1) << window;
                return '0;
        endfunction

        task automatic addRandomRows();
                rowT         r;
                int unsigned window;
                int unsigned offset;
                for (int n = 0; n < NumRandom; n++)
                begin
                        window = $urandom_range(5, 0);   // 4 and 5 fall outside the map
                        offset = $urandom_range(WindowSize - 1, 0);
                        if (window == 0 && $urandom_range(3, 0) == 0)
                                offset = $urandom_range(15, 0);   // Around the guard region
                        r.write   = 1'($urandom_range(1, 0));
                        r.addr    = ahbApbPkg::addrT'(window * WindowSize + offset);
                        r.size    = ahbApbPkg::sizeT'($urandom_range(3, 0));
                        r.wdata   = $urandom;
                        r.prdata  = $urandom;
                        r.expLane = expectedLane(r.size, r.addr, r.write ? r.wdata : r.prdata);
                        r.expSel  = expectedSel(r.addr);
                        rows.push_back(r);
                end
        endtask

        // Phase 0 is write wait, 1 setup, 2 access
        task automatic verifyPhase(input rowT row, input int phase);
                checkAddr("Paddr", Paddr, row.addr);
                checkFlag("Pwrite", Pwrite, row.write);
                if (phase == 0)
                begin
                        checkFlag("Penable in write wait", Penable, 1'b0);
                        checkSel("Pselx in write wait", Pselx, '0);
                end
                else if (phase <= 2)
                begin
                        checkFlag("Penable", Penable, 1'(phase == 2));
                        checkSel("Pselx", Pselx, row.expSel);
                        if (row.write)
                                checkData("Pwdata", Pwdata, row.expLane);
                end
                else
                        stopOnMismatch("Hreadyout after access", "0", "1");
        endtask

        task automatic runTransfer(input rowT row);
                int   cycle;
                logic ready;
                @(posedge Hclk);
                #(DriveDelay);
                curRow = row;
                valid  = 1'b1;
                Haddr  = row.addr;
                Hwrite = row.write;
                Hsize  = row.size;
                Hwdata = ~row.wdata;   // Data phase not reached yet
                @(negedge Hclk);
                checkFlag("Hreadyout before accept", Hreadyout, 1'b1);
                @(posedge Hclk);
                #(DriveDelay);
                valid  = 1'b0;
                Haddr  = ~row.addr;   // Idle address phase, held through the wait states
                Hwrite = ~row.write;
                Hsize  = ~row.size;
                Hwdata = row.wdata;
                cycle  = 0;
                ready  = 1'b0;
                while (!ready)
                begin
                        @(negedge Hclk);
                        cycle++;
                        ready = Hreadyout;
                        if (!ready)
                                verifyPhase(row, row.write ? cycle - 1 : cycle);
                end
                checkCount("latency", cycle, row.write ? 4 : 3);
                checkFlag("Penable after transfer", Penable, 1'b0);
                checkSel("Pselx after transfer", Pselx, '0);
                if (!row.write)
                        checkData("Hrdata", Hrdata, row.expLane);
        endtask

        task automatic runWatchdog(input realtime limit);
                #(limit);
                $display("Run timed out after %0t, the bridge stopped responding", $time);
                $display("ERRORS FOUND");
                $fatal(1, "Watchdog expired");
        endtask

        initial
        begin
                realtime limit;
                void'($urandom(Seed));
                valid     = 1'b0;
                Haddr     = '0;
                Hwrite    = 1'b0;
                Hsize     = ahbApbPkg::SizeByte;
                Hwdata    = '0;
                curRow    = '0;
                step      = 0;
                foreach (FixedRows[i])
                        rows.push_back(FixedRows[i]);
                addRandomRows();
                limit = realtime'((rows.size() * CyclesPerRow + ResetCycles) * ClockPeriod);
                fork
                        runWatchdog(limit);
                join_none
                @(posedge Hresetn);
                @(negedge Hclk);
                checkFlag("Hreadyout after reset", Hreadyout, 1'b1);
                checkFlag("Penable after reset", Penable, 1'b0);
                checkSel("Pselx after reset", Pselx, '0);
                foreach (rows[i])
                begin
                        step = i + 1;
                        runTransfer(rows[i]);
                end
                $display("NO ERRORS");
                $finish;
        end

endmodule

`default_nettype wire

// ==== sim/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
        parameter int Period      = 40,
        parameter int ResetCycles = 8,
        parameter int DriveDelay  = 2
) (
        output logic Hclk,
        output logic Hresetn
);

        initial
        begin
                Hclk = 1'b0;
                forever
                        #(Period / 2) Hclk = ~Hclk;
        end

        // Release lands just after an edge, like the other inputs
        initial
        begin
                Hresetn = 1'b0;
                repeat (ResetCycles) @(posedge Hclk);
                #(DriveDelay) Hresetn = 1'b1;
        end

endmodule

`default_nettype wire
